//--- hw/readout_pkg.sv
`default_nettype none

package readout_pkg;

  ////////////////////////////////////////////////////////////
  // link word and stream beat
  ////////////////////////////////////////////////////////////

  typedef logic [31:0] word_t;        // one 32-bit link word

  // a beat on any 32-bit stream: data plus end-of-frame flag
  typedef struct packed {
    word_t data;                      // payload word
    logic  last;                      // final word of a frame
  } stream_beat_t;                    // 33 bits

  // word position inside a held memory burst
  // 8 bits covers bursts of up to 256 words
  typedef logic [7:0] burst_word_cnt_t;

  ////////////////////////////////////////////////////////////
  // readout control
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    st_cmd       = 2'd0,              // link carries command responses
    st_cmd_drain = 2'd1,              // readout asked, finishing open command frame
    st_ddr3      = 2'd2               // link carries memory data
  } readout_state_e;

  // strobes from the link mux, one cycle each, on the edge the beat moves
  typedef struct packed {
    logic cmd_accept;                 // a command beat moved
    logic cmd_last;                   // ... and it closed the frame
    logic ddr3_accept;                // a memory word moved
    logic ddr3_last;                  // ... and it was the final word of the readout
  } mux_accept_t;

endpackage

`default_nettype wire

//--- hw/burst_splitter.sv
`default_nettype none

// holds one memory burst and hands it out as 32-bit link words,
// word 0 (lowest bits) first
module burst_splitter #(
  parameter int unsigned burst_words = 4    // 32-bit words per burst
) (
  input  wire  logic                                     clk125,
  input  wire  logic                                     rst,
  // burst input: data in the low bits, last flag in the top bit
  input  wire  logic [burst_words*32:0]                  ddr3_burst,
  input  wire  logic                                     ddr3_valid,
  output logic                                           ddr3_ready,
  // word stream toward the link mux
  output readout_pkg::stream_beat_t                      split_beat,
  output logic                                           split_valid,
  input  wire  logic                                     split_ready
);

  localparam int unsigned data_bits = burst_words * $bits(readout_pkg::word_t);
  localparam readout_pkg::burst_word_cnt_t final_idx =
    readout_pkg::burst_word_cnt_t'(burst_words - 1);

  readout_pkg::word_t [burst_words-1:0] burst_q;  // held burst, payload only
  logic                                 burst_last_q; // held burst ends the readout
  readout_pkg::burst_word_cnt_t         word_idx;  // next word to send
  logic                                 final_word; // word_idx points at top word
  logic                                 word_move;  // a word leaves this cycle
  logic                                 burst_load; // a new burst comes in

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  assign final_word = (word_idx == final_idx);
  assign word_move  = split_valid && split_ready;

  // room when empty, or when the top word drains on this edge
  assign ddr3_ready = !split_valid || (word_move && final_word);
  assign burst_load = ddr3_valid && ddr3_ready;

  // output word, last only on the top word of a final burst
  assign split_beat.data = burst_q[word_idx];
  assign split_beat.last = burst_last_q && final_word;

  ////////////////////////////////////////////////////////////
  // burst register and word counter
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk125) begin
    if (burst_load) begin
      burst_q      <= ddr3_burst[data_bits-1:0];
      burst_last_q <= ddr3_burst[data_bits];     // last flag rides above the data
    end
  end

  always_ff @(posedge clk125) begin
    if (rst) begin
      split_valid <= 1'b0;
      word_idx    <= '0;
    end else if (burst_load) begin
      split_valid <= 1'b1;                        // word 0 shows up next cycle
      word_idx    <= '0;
    end else if (word_move) begin
      if (final_word) begin
        split_valid <= 1'b0;                      // burst fully sent
      end else begin
        word_idx <= word_idx + 1'b1;
      end
    end
  end

  // words of a held burst stay in place until its top word is on its way out
  burst_no_overwrite: assert property (@(posedge clk125) disable iff (rst)
    (split_valid && !(word_move && final_word)) |=>
      (split_valid && word_idx == ($past(word_move) ? $past(word_idx) + 1'b1 : $past(word_idx))))
    else $error("burst_splitter took a burst while words of the held one remained");

endmodule

`default_nettype wire

//--- hw/link_tx_mux.sv
`default_nettype none

// 2:1 stream mux onto the link to the master FPGA
// pause from the master freezes everything, output bit order is swapped
module link_tx_mux (
  input  wire  logic                      clk125,
  input  wire  logic                      rst,
  input  wire  logic                      pause,       // async, from master
  input  wire  logic                      use_ddr3,    // source select from controller
  input  wire  readout_pkg::stream_beat_t cmd_beat,
  input  wire  logic                      cmd_valid,
  output logic                            cmd_ready,
  input  wire  readout_pkg::stream_beat_t split_beat,
  input  wire  logic                      split_valid,
  output logic                            split_ready,
  output readout_pkg::stream_beat_t       link_beat,
  output logic                            link_valid,
  input  wire  logic                      link_ready,
  output readout_pkg::mux_accept_t        accept
);

  logic                      pause_meta;   // first sync stage
  logic                      pause_sync;   // safe to use on clk125
  readout_pkg::stream_beat_t sel_beat;     // beat of the selected source
  logic                      sel_valid;
  logic                      go_ready;     // link ready and not paused

  // two-flop synchronizer on pause
  always_ff @(posedge clk125) begin
    if (rst) begin
      pause_meta <= 1'b0;
      pause_sync <= 1'b0;
    end else begin
      pause_meta <= pause;
      pause_sync <= pause_meta;
    end
  end

  ////////////////////////////////////////////////////////////
  // source select
  ////////////////////////////////////////////////////////////

  assign sel_beat  = use_ddr3 ? split_beat : cmd_beat;
  assign sel_valid = use_ddr3 ? split_valid : cmd_valid;

  assign link_valid     = sel_valid && !pause_sync;         // hold off while paused
  assign link_beat.data = {<<{sel_beat.data}};              // bit 0 out = bit 31 in
  assign link_beat.last = sel_beat.last;

  // only the active source sees ready
  assign go_ready    = link_ready && !pause_sync;
  assign cmd_ready   = !use_ddr3 && go_ready;
  assign split_ready = use_ddr3 && go_ready;

  // which beat moved this cycle, for the readout controller
  assign accept.cmd_accept  = cmd_valid && cmd_ready;
  assign accept.cmd_last    = cmd_valid && cmd_ready && cmd_beat.last;
  assign accept.ddr3_accept = split_valid && split_ready;
  assign accept.ddr3_last   = split_valid && split_ready && split_beat.last;

  sources_exclusive: assert property (@(posedge clk125) disable iff (rst)
    !(cmd_ready && split_ready))
    else $error("link_tx_mux offered ready to both sources");

endmodule

`default_nettype wire

//--- hw/readout_ctrl.sv
`default_nettype none

// decides which source owns the link
// switches only between frames so command frames are never cut
module readout_ctrl (
  input  wire  logic                    clk125,
  input  wire  logic                    rst,
  input  wire  logic                    rd_start,     // one-cycle readout request
  input  wire  readout_pkg::mux_accept_t accept,
  output logic                          use_ddr3,
  output logic                          readout_done  // one-cycle pulse at readout end
);

  readout_pkg::readout_state_e state;
  readout_pkg::readout_state_e state_next;
  logic                        cmd_open;      // command frame partly sent
  logic                        cmd_open_next; // frame state after this cycle's beat

  ////////////////////////////////////////////////////////////
  // command frame tracking
  ////////////////////////////////////////////////////////////

  // a beat with last closes the frame, any other accepted beat opens it
  always_comb begin
    cmd_open_next = cmd_open;
    if (accept.cmd_last) begin
      cmd_open_next = 1'b0;
    end else if (accept.cmd_accept) begin
      cmd_open_next = 1'b1;
    end
  end

  always_ff @(posedge clk125) begin
    if (rst) begin
      cmd_open <= 1'b0;
    end else begin
      cmd_open <= cmd_open_next;
    end
  end

  ////////////////////////////////////////////////////////////
  // source FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      readout_pkg::st_cmd: begin
        if (rd_start) begin  // wait for the open frame, if any
          state_next = cmd_open_next ? readout_pkg::st_cmd_drain : readout_pkg::st_ddr3;
        end
      end
      readout_pkg::st_cmd_drain: begin
        if (accept.cmd_last) state_next = readout_pkg::st_ddr3;  // frame done
      end
      readout_pkg::st_ddr3: begin
        if (accept.ddr3_last) state_next = readout_pkg::st_cmd;  // readout done
      end
      default: state_next = readout_pkg::st_cmd;
    endcase
  end

  always_ff @(posedge clk125) begin
    if (rst) begin
      state        <= readout_pkg::st_cmd;
      readout_done <= 1'b0;
    end else begin
      state        <= state_next;
      readout_done <= (state == readout_pkg::st_ddr3) && accept.ddr3_last;
    end
  end

  assign use_ddr3 = (state == readout_pkg::st_ddr3);

  // switching sources in the middle of a command frame would reorder the link
  no_switch_mid_frame: assert property (@(posedge clk125) disable iff (rst)
    !$stable(use_ddr3) |-> !cmd_open)
    else $error("use_ddr3 changed while a command frame was open");

endmodule

`default_nettype wire

//--- hw/channel_readout_top.sv
`default_nettype none

// readout path of one channel: command responses and memory data
// merged onto the single link toward the master FPGA
module channel_readout_top #(
  parameter int unsigned burst_words = 4    // 32-bit words per memory burst
) (
  input  wire  logic                      clk125,
  input  wire  logic                      rst,
  input  wire  logic                      pause,        // readout pause from master
  input  wire  logic                      rd_start,     // request one readout
  // command responses
  input  wire  readout_pkg::stream_beat_t cmd_beat,
  input  wire  logic                      cmd_valid,
  output logic                            cmd_ready,
  // memory bursts, last flag in the top bit
  input  wire  logic [burst_words*32:0]   ddr3_burst,
  input  wire  logic                      ddr3_valid,
  output logic                            ddr3_ready,
  // link toward master
  output readout_pkg::stream_beat_t       link_beat,
  output logic                            link_valid,
  input  wire  logic                      link_ready,
  output logic                            readout_done
);

  readout_pkg::stream_beat_t split_beat;   // split memory words
  logic                      split_valid;
  logic                      split_ready;
  logic                      use_ddr3;     // link owned by memory data
  readout_pkg::mux_accept_t  accept;       // accept strobes back to the FSM

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////

  burst_splitter #(
    .burst_words (burst_words)
  ) burst_splitter_i (
    .clk125      (clk125),
    .rst         (rst),
    .ddr3_burst  (ddr3_burst),
    .ddr3_valid  (ddr3_valid),
    .ddr3_ready  (ddr3_ready),
    .split_beat  (split_beat),
    .split_valid (split_valid),
    .split_ready (split_ready)
  );

  link_tx_mux link_tx_mux_i (
    .clk125      (clk125),
    .rst         (rst),
    .pause       (pause),
    .use_ddr3    (use_ddr3),
    .cmd_beat    (cmd_beat),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .split_beat  (split_beat),
    .split_valid (split_valid),
    .split_ready (split_ready),
    .link_beat   (link_beat),
    .link_valid  (link_valid),
    .link_ready  (link_ready),
    .accept      (accept)
  );

  // control
  readout_ctrl readout_ctrl_i (
    .clk125       (clk125),
    .rst          (rst),
    .rd_start     (rd_start),
    .accept       (accept),
    .use_ddr3     (use_ddr3),
    .readout_done (readout_done)
  );

endmodule

`default_nettype wire

//--- testbench/tb_channel_readout.sv
`default_nettype none

module tb_channel_readout;
  timeunit 1ns;
  timeprecision 100ps;

  logic clk125 = 1'b0;
  logic rst, pause, rd_start, cmd_valid, ddr3_valid, link_ready;
  logic cmd_ready, ddr3_ready, link_valid, readout_done;
  logic [128:0] ddr3_burst;                  // {last, w3, w2, w1, w0}
  readout_pkg::stream_beat_t cmd_beat, link_beat;

  readout_pkg::stream_beat_t cmd_q[$];       // command beats still to offer
  logic [128:0]              burst_q[$];     // bursts still to offer
  logic [33:0]               exp_q[$];       // {done, last, data} in link order
  logic   cmd_moved = 1'b0, ddr3_moved = 1'b0;
  logic   done_due = 1'b0;                   // readout_done expected on this edge
  logic   p1 = 1'b0, p2 = 1'b0;              // pause as the DUT synchronizer sees it
  integer seed = 32'he5e81020;
  integer accepted_cnt = 0;
  integer data_errs = 0, timing_errs = 0, timeouts = 0;

  channel_readout_top #(.burst_words(4)) dut_i (
    .clk125(clk125), .rst(rst), .pause(pause), .rd_start(rd_start),
    .cmd_beat(cmd_beat), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
    .ddr3_burst(ddr3_burst), .ddr3_valid(ddr3_valid), .ddr3_ready(ddr3_ready),
    .link_beat(link_beat), .link_valid(link_valid), .link_ready(link_ready),
    .readout_done(readout_done)
  );

  always #50 clk125 = ~clk125;               // 100 ns period

  ////////////////////////////////////////////////////////////
  // drivers, all on the falling edge
  ////////////////////////////////////////////////////////////

  always @(posedge clk125) begin
    cmd_moved  <= cmd_valid && cmd_ready;
    ddr3_moved <= ddr3_valid && ddr3_ready;
  end

  always @(negedge clk125) begin
    link_ready = ($random(seed) & 3) != 0;   // ready about 3 cycles in 4
    if (cmd_moved) cmd_valid = 1'b0;
    if (!cmd_valid && cmd_q.size() > 0) begin
      cmd_beat  = cmd_q.pop_front();
      cmd_valid = 1'b1;
    end
    if (ddr3_moved) ddr3_valid = 1'b0;
    if (!ddr3_valid && burst_q.size() > 0) begin
      ddr3_burst = burst_q.pop_front();
      ddr3_valid = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // link monitor
  ////////////////////////////////////////////////////////////

  always @(posedge clk125) begin
    logic        hit;
    logic [33:0] exp_e;
    if (!rst) begin
      hit = link_valid && link_ready;
      assert (readout_done === done_due) else begin
        timing_errs++;
        $display("Error readout_done expected %h got %h", done_due, readout_done);
      end
      assert (!(p2 && (link_valid || cmd_ready))) else begin
        timing_errs++;
        $display("Error link_valid %h cmd_ready %h while paused, expected 0",
                 link_valid, cmd_ready);
      end
      done_due = 1'b0;
      if (hit) begin
        accepted_cnt++;
        assert (exp_q.size() != 0) else begin
          data_errs++;
          $display("the link carried a beat after all expected words were seen");
        end
        if (exp_q.size() != 0) begin
          exp_e = exp_q.pop_front();
          assert (link_beat.data === exp_e[31:0] && link_beat.last === exp_e[32]) else begin
            data_errs++;
            $display("Error link_beat expected %h last %h got %h last %h",
                     exp_e[31:0], exp_e[32], link_beat.data, link_beat.last);
          end
          done_due = exp_e[33];              // pulse due one edge later
        end
      end
      p2 = p1;                               // two-stage delay like the DUT
      p1 = pause;
    end
  end

  ////////////////////////////////////////////////////////////
  // waits, each with its own limit
  ////////////////////////////////////////////////////////////

  task automatic wait_accepted(input integer n);
    integer t;
    for (t = 0; t < 1000 && accepted_cnt < n; t++) @(negedge clk125);
    if (accepted_cnt < n) begin
      timeouts++;
      $display("timed out waiting for %0d link beats, only %0d arrived", n, accepted_cnt);
    end
  endtask

  task automatic drain_link(input integer n);
    integer t;
    for (t = 0; t < 2000 && accepted_cnt < n; t++) @(negedge clk125);
    @(negedge clk125);                       // let a pending done pulse be checked
    if (accepted_cnt < n) begin
      timeouts++;
      $display("timed out with %0d expected link words never sent", n - accepted_cnt);
    end
  endtask

  task automatic pulse_rd_start();
    rd_start = 1'b1;
    @(negedge clk125);
    rd_start = 1'b0;
  endtask

  task automatic hold_pause(input integer cycles);
    pause = 1'b1;
    repeat (cycles) @(negedge clk125);
    pause = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus from the golden file
  ////////////////////////////////////////////////////////////

  initial begin
    integer fd, n, exp_lines;
    string  line;
    string  act_q[$];                        // stimulus records in file order
    integer drain_at[$];                     // link words due at each drain point
    logic [31:0] a, b, c, d, e, f;
    rst = 1'b1;
    pause = 1'b0;
    rd_start = 1'b0;
    cmd_beat = '0;
    cmd_valid = 1'b0;
    ddr3_burst = '0;
    ddr3_valid = 1'b0;
    link_ready = 1'b0;
    repeat (3) @(posedge clk125);
    @(negedge clk125) rst = 1'b0;
    repeat (2) begin                         // quiet state after reset
      @(negedge clk125);
      assert (!link_valid && !readout_done && ddr3_ready) else begin
        timing_errs++;
        $display("Error after reset link_valid %h readout_done %h ddr3_ready %h, expected 0 0 1",
                 link_valid, readout_done, ddr3_ready);
      end
    end
    fd = $fopen("testbench/readout_golden.txt", "r");
    if (fd == 0) begin
      timeouts++;
      $display("could not open the golden file");
    end else begin
      // expected link words go straight into the queue, other records run in file order
      exp_lines = 0;
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() == 0) continue;
        case (line.getc(0))
          "E": begin
            n = $sscanf(line, "E %h %h %h", a, b, f);
            exp_q.push_back({f[0], b[0], a});
            exp_lines++;
          end
          "S": begin
            drain_at.push_back(exp_lines);   // every word listed so far
            act_q.push_back(line);
          end
          "C", "B", "P", "M", "R": act_q.push_back(line);
          default: ;                         // comments and blank lines
        endcase
      end
      $fclose(fd);
      while (act_q.size() > 0 && timeouts == 0) begin
        line = act_q.pop_front();
        case (line.getc(0))
          "C": begin
            n = $sscanf(line, "C %h %h", a, b);
            cmd_q.push_back('{data: a, last: b[0]});
          end
          "B": begin
            n = $sscanf(line, "B %h %h %h %h %h", a, b, c, d, e);
            burst_q.push_back({e[0], d, c, b, a});
          end
          "P": begin
            n = $sscanf(line, "P %d", a);
            hold_pause(a);
          end
          "M": begin
            n = $sscanf(line, "M %d", a);
            wait_accepted(a);
          end
          "R": pulse_rd_start();
          "S": drain_link(drain_at.pop_front());
          default: ;
        endcase
      end
    end
    $display("errors: %0d data, %0d timing, %0d timeouts", data_errs, timing_errs, timeouts);
    if (data_errs == 0 && timing_errs == 0 && timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
hw/readout_pkg.sv
hw/burst_splitter.sv
hw/link_tx_mux.sv
hw/readout_ctrl.sv
hw/channel_readout_top.sv
testbench/tb_channel_readout.sv

//--- Bender.yml
package:
  name: channel_readout

sources:
  - files:
      - hw/readout_pkg.sv
      - hw/burst_splitter.sv
      - hw/link_tx_mux.sv
      - hw/readout_ctrl.sv
      - hw/channel_readout_top.sv
  - target: test
    files:
      - testbench/tb_channel_readout.sv

//--- testbench/readout_golden.txt
# C data last | B w0 w1 w2 w3 last | E data last done | R start | P cycles | M beats | S drain
# E words are bit-reversed source words in link order
C 00000001 0
C 12345678 1
C A5A5F00F 0
C 0000FFFF 0
C 80000001 1
E 80000000 0 0
E 1E6A2C48 1 0
E F00FA5A5 0 0
E FFFF0000 0 0
E 80000001 1 0
S
B 00000010 00000020 00000030 00000040 0
B 00000050 00000060 00000070 00000080 1
E 08000000 0 0
E 04000000 0 0
E 0C000000 0 0
E 02000000 0 0
E 0A000000 0 0
E 06000000 0 0
E 0E000000 0 0
E 01000000 1 1
R
P 6
S
C DEADBEEF 0
C 0F0F0F0F 0
C 00FF00FF 0
C CAFEF00D 1
M 14
R
B 11111111 22222222 44444444 88888888 1
C 13579BDF 1
E F77DB57B 0 0
E F0F0F0F0 0 0
E FF00FF00 0 0
E B00F7F53 1 0
E 88888888 0 0
E 44444444 0 0
E 22222222 0 0
E 11111111 1 1
E FBD9EAC8 1 0
S
